//--- dmi_subsys.f
logic/dmi_pkg.sv
logic/dm_map_pkg.sv
logic/sync_2ff.sv
logic/cdc_handshake.sv
logic/dmi_cdc.sv
logic/dmi_regfile.sv
logic/dmi_subsys_top.sv
bench/dmi_subsys_properties.sv
bench/dmi_subsys_tb.sv

//--- Bender.yml
package:
  name: dmi_subsys

sources:
  - files:
      - logic/dmi_pkg.sv
      - logic/dm_map_pkg.sv
      - logic/sync_2ff.sv
      - logic/cdc_handshake.sv
      - logic/dmi_cdc.sv
      - logic/dmi_regfile.sv
      - logic/dmi_subsys_top.sv
  - target: test
    files:
      - bench/dmi_subsys_properties.sv
      - bench/dmi_subsys_tb.sv

//--- bench/dmi_subsys_tb.sv
`timescale 1ns/1ps

module dmi_subsys_tb;

  localparam int unsigned NumData = 4;
  // Negedges allowed per wait
  localparam int unsigned Timeout = 300;

  logic                          tck_i = 1'b0;
  logic                          clk_i = 1'b0;
  logic                          trst_ni;
  logic                          rst_ni;
  logic                          testmode_i;
  logic                          test_rst_ni;
  logic                          dmi_req_valid_i;
  logic                          dmi_req_ready_o;
  logic [dmi_pkg::AddrWidth-1:0] dmi_req_addr_i;
  dmi_pkg::dmi_op_e              dmi_req_op_i;
  logic [dmi_pkg::DataWidth-1:0] dmi_req_data_i;
  logic                          dmi_resp_valid_o;
  logic                          dmi_resp_ready_i;
  logic [dmi_pkg::DataWidth-1:0] dmi_resp_data_o;
  dmi_pkg::dmi_resp_e            dmi_resp_code_o;
  logic                          dmi_cdc_clear_i;

  // Expected data register contents
  logic [31:0] model [NumData];
  logic [31:0] lcg_state = 32'h89b5_090b;
  int unsigned checks;
  int unsigned errors;

  // 20 ns JTAG clock, 14 ns core clock
  always #10 tck_i = ~tck_i;
  always #7 clk_i = ~clk_i;

  dmi_subsys_top #(
    .NumData(NumData)
  ) DUT (
    .tck_i            (tck_i),
    .trst_ni          (trst_ni),
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .testmode_i       (testmode_i),
    .test_rst_ni      (test_rst_ni),
    .dmi_req_valid_i  (dmi_req_valid_i),
    .dmi_req_ready_o  (dmi_req_ready_o),
    .dmi_req_addr_i   (dmi_req_addr_i),
    .dmi_req_op_i     (dmi_req_op_i),
    .dmi_req_data_i   (dmi_req_data_i),
    .dmi_resp_valid_o (dmi_resp_valid_o),
    .dmi_resp_ready_i (dmi_resp_ready_i),
    .dmi_resp_data_o  (dmi_resp_data_o),
    .dmi_resp_code_o  (dmi_resp_code_o),
    .dmi_cdc_clear_i  (dmi_cdc_clear_i)
  );

  // LCG step
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  // Offer one request, return after its transfer edge
  task automatic send_req(input logic [dmi_pkg::AddrWidth-1:0] addr,
                          input dmi_pkg::dmi_op_e op, input logic [31:0] data);
    int unsigned cycles;
    cycles          = 0;
    dmi_req_valid_i = 1'b1;
    dmi_req_addr_i  = addr;
    dmi_req_op_i    = op;
    dmi_req_data_i  = data;
    while (!dmi_req_ready_o && cycles < Timeout) begin
      @(negedge tck_i);
      cycles++;
    end
    if (!dmi_req_ready_o) begin
      errors++;
      $display("timeout at %0t ns: request to address %h never accepted", $time, addr);
    end
    @(negedge tck_i);
    dmi_req_valid_i = 1'b0;
  endtask

  task automatic wait_resp_valid();
    int unsigned cycles;
    cycles = 0;
    while (!dmi_resp_valid_o && cycles < Timeout) begin
      @(negedge tck_i);
      cycles++;
    end
    if (!dmi_resp_valid_o) begin
      errors++;
      $display("timeout at %0t ns: no response arrived", $time);
    end
  endtask

  // Data only defined for successful responses
  task automatic take_resp(input logic [31:0] exp_data, input dmi_pkg::dmi_resp_e exp_code);
    dmi_resp_ready_i = 1'b1;
    wait_resp_valid();
    check_value("dmi_resp_code_o", dmi_resp_code_o, exp_code);
    if (exp_code == dmi_pkg::DMI_SUCCESS) begin
      check_value("dmi_resp_data_o", dmi_resp_data_o, exp_data);
    end
    @(negedge tck_i);
    dmi_resp_ready_i = 1'b0;
  endtask

  task automatic dmi_access(input logic [dmi_pkg::AddrWidth-1:0] addr,
                            input dmi_pkg::dmi_op_e op, input logic [31:0] wdata,
                            input logic [31:0] exp_data, input dmi_pkg::dmi_resp_e exp_code);
    send_req(addr, op, wdata);
    take_resp(exp_data, exp_code);
  endtask

  task automatic read_data_regs();
    for (int unsigned k = 0; k < NumData; k++) begin
      dmi_access(dm_map_pkg::DataBaseAddr + k[6:0], dmi_pkg::DMI_READ, '0, model[k],
                 dmi_pkg::DMI_SUCCESS);
    end
  endtask

  // Fresh LCG data into every data register
  task automatic write_data_regs();
    for (int unsigned k = 0; k < NumData; k++) begin
      model[k] = lcg_next();
      dmi_access(dm_map_pkg::DataBaseAddr + k[6:0], dmi_pkg::DMI_WRITE, model[k], '0,
                 dmi_pkg::DMI_SUCCESS);
    end
  endtask

  task automatic report_test(input string name, input int unsigned errors_before);
    $display("test %s finished at %0t ns with %0d errors", name, $time, errors - errors_before);
  endtask

  task automatic test_reset_values();
    int unsigned err_start;
    err_start = errors;
    read_data_regs();
    dmi_access(dm_map_pkg::IdAddr, dmi_pkg::DMI_READ, '0, dm_map_pkg::IdValue,
               dmi_pkg::DMI_SUCCESS);
    report_test("reset_values", err_start);
  endtask

  task automatic test_write_read();
    int unsigned err_start;
    err_start = errors;
    write_data_regs();
    read_data_regs();
    report_test("write_read", err_start);
  endtask

  task automatic test_errors();
    int unsigned err_start;
    err_start = errors;
    dmi_access(dm_map_pkg::IdAddr, dmi_pkg::DMI_WRITE, lcg_next(), '0, dmi_pkg::DMI_FAILED);
    dmi_access(dm_map_pkg::IdAddr, dmi_pkg::DMI_READ, '0, dm_map_pkg::IdValue,
               dmi_pkg::DMI_SUCCESS);
    dmi_access(7'h40, dmi_pkg::DMI_READ, '0, '0, dmi_pkg::DMI_FAILED);
    // Just below the data window
    dmi_access(7'h03, dmi_pkg::DMI_WRITE, lcg_next(), '0, dmi_pkg::DMI_FAILED);
    dmi_access(7'h00, dmi_pkg::DMI_NOP, lcg_next(), '0, dmi_pkg::DMI_SUCCESS);
    // Failed writes left the data alone
    read_data_regs();
    report_test("errors", err_start);
  endtask

  task automatic test_backpressure();
    int unsigned err_start;
    err_start        = errors;
    dmi_resp_ready_i = 1'b0;
    send_req(dm_map_pkg::DataBaseAddr, dmi_pkg::DMI_READ, '0);
    wait_resp_valid();
    // Second request queues behind the held response
    send_req(dm_map_pkg::IdAddr, dmi_pkg::DMI_READ, '0);
    for (int unsigned k = 0; k < 20; k++) begin
      check_value("dmi_resp_valid_o", dmi_resp_valid_o, 1'b1);
      check_value("dmi_resp_data_o", dmi_resp_data_o, model[0]);
      check_value("dmi_resp_code_o", dmi_resp_code_o, dmi_pkg::DMI_SUCCESS);
      @(negedge tck_i);
    end
    take_resp(model[0], dmi_pkg::DMI_SUCCESS);
    take_resp(dm_map_pkg::IdValue, dmi_pkg::DMI_SUCCESS);
    report_test("backpressure", err_start);
  endtask

  task automatic test_clear();
    int unsigned err_start;
    err_start = errors;
    write_data_regs();
    dmi_cdc_clear_i = 1'b1;
    repeat (4) @(negedge tck_i);
    dmi_cdc_clear_i = 1'b0;
    repeat (4) @(negedge tck_i);
    for (int unsigned k = 0; k < NumData; k++) begin
      model[k] = dm_map_pkg::DataResetValue;
    end
    read_data_regs();
    // Same again through the external test reset
    testmode_i = 1'b1;
    write_data_regs();
    test_rst_ni = 1'b0;
    repeat (4) @(negedge tck_i);
    test_rst_ni = 1'b1;
    repeat (4) @(negedge tck_i);
    for (int unsigned k = 0; k < NumData; k++) begin
      model[k] = dm_map_pkg::DataResetValue;
    end
    read_data_regs();
    testmode_i = 1'b0;
    report_test("clear", err_start);
  endtask

  initial begin
    trst_ni          = 1'b0;
    rst_ni           = 1'b0;
    testmode_i       = 1'b0;
    test_rst_ni      = 1'b1;
    dmi_req_valid_i  = 1'b0;
    dmi_req_addr_i   = '0;
    dmi_req_op_i     = dmi_pkg::DMI_NOP;
    dmi_req_data_i   = '0;
    dmi_resp_ready_i = 1'b0;
    dmi_cdc_clear_i  = 1'b0;
    checks           = 0;
    errors           = 0;
    for (int unsigned k = 0; k < NumData; k++) begin
      model[k] = dm_map_pkg::DataResetValue;
    end
    repeat (3) @(negedge tck_i);
    trst_ni = 1'b1;
    rst_ni  = 1'b1;
    repeat (4) @(negedge tck_i);
    test_reset_values();
    test_write_read();
    test_errors();
    test_backpressure();
    test_clear();
    errors = errors + DUT.u_properties.assert_fails;
    $display("checks run %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- bench/dmi_subsys_properties.sv
`timescale 1ns/1ps

module dmi_subsys_properties (
  input logic                          tck_i,
  input logic                          trst_ni,
  input logic                          dmi_req_valid_i,
  input logic                          dmi_req_ready_o,
  input logic                          dmi_resp_valid_o,
  input logic                          dmi_resp_ready_i,
  input logic [dmi_pkg::DataWidth-1:0] dmi_resp_data_o,
  input dmi_pkg::dmi_resp_e            dmi_resp_code_o
);

  // Requests accepted and not yet answered
  int outstanding_q;
  // Failed assertion count
  int unsigned assert_fails = 0;

  always_ff @(posedge tck_i or negedge trst_ni) begin
    if (!trst_ni) begin
      outstanding_q <= 0;
    end else begin
      outstanding_q <= outstanding_q + int'(dmi_req_valid_i && dmi_req_ready_o)
                                     - int'(dmi_resp_valid_o && dmi_resp_ready_i);
    end
  end

  // No handshake offered during JTAG reset
  idle_in_reset: assert property (@(posedge tck_i)
    !trst_ni |-> !dmi_req_ready_o && !dmi_resp_valid_o)
    else begin
      $error("request ready or response valid while trst_ni is low");
      assert_fails++;
    end

  // Stalled response keeps its fields
  resp_held: assert property (@(posedge tck_i) disable iff (!trst_ni)
    dmi_resp_valid_o && !dmi_resp_ready_i |=>
      dmi_resp_valid_o && $stable(dmi_resp_data_o) && $stable(dmi_resp_code_o))
    else begin
      $error("response changed while stalled");
      assert_fails++;
    end

  // Every response answers an accepted request
  resp_has_request: assert property (@(posedge tck_i) disable iff (!trst_ni)
    $rose(dmi_resp_valid_o) |-> outstanding_q > 0)
    else begin
      $error("response without an outstanding request");
      assert_fails++;
    end

endmodule

bind dmi_subsys_top dmi_subsys_properties u_properties (
  .tck_i            (tck_i),
  .trst_ni          (trst_ni),
  .dmi_req_valid_i  (dmi_req_valid_i),
  .dmi_req_ready_o  (dmi_req_ready_o),
  .dmi_resp_valid_o (dmi_resp_valid_o),
  .dmi_resp_ready_i (dmi_resp_ready_i),
  .dmi_resp_data_o  (dmi_resp_data_o),
  .dmi_resp_code_o  (dmi_resp_code_o)
);

//--- logic/dmi_subsys_top.sv
`timescale 1ns/1ps

module dmi_subsys_top #(
  parameter int unsigned NumData = 4
) (
  // Clocks and resets
  input  logic                          tck_i,
  input  logic                          trst_ni,
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          testmode_i,
  input  logic                          test_rst_ni,
  // JTAG-side DMI request
  input  logic                          dmi_req_valid_i,
  output logic                          dmi_req_ready_o,
  input  logic [dmi_pkg::AddrWidth-1:0] dmi_req_addr_i,
  input  dmi_pkg::dmi_op_e              dmi_req_op_i,
  input  logic [dmi_pkg::DataWidth-1:0] dmi_req_data_i,
  // JTAG-side DMI response
  output logic                          dmi_resp_valid_o,
  input  logic                          dmi_resp_ready_i,
  output logic [dmi_pkg::DataWidth-1:0] dmi_resp_data_o,
  output dmi_pkg::dmi_resp_e            dmi_resp_code_o,
  // Core-side clear
  input  logic                          dmi_cdc_clear_i
);

  // Core-domain wires between crossing and target
  logic                          core_rst_n;
  logic                          core_req_valid;
  logic                          core_req_ready;
  logic [dmi_pkg::AddrWidth-1:0] core_req_addr;
  dmi_pkg::dmi_op_e              core_req_op;
  logic [dmi_pkg::DataWidth-1:0] core_req_data;
  logic                          core_resp_valid;
  logic                          core_resp_ready;
  logic [dmi_pkg::DataWidth-1:0] core_resp_data;
  dmi_pkg::dmi_resp_e            core_resp_code;

  // Both crossings and core reset generation
  dmi_cdc u_dmi_cdc (
    .testmode_i        (testmode_i),
    .test_rst_ni       (test_rst_ni),
    .tck_i             (tck_i),
    .trst_ni           (trst_ni),
    .jtag_req_valid_i  (dmi_req_valid_i),
    .jtag_req_ready_o  (dmi_req_ready_o),
    .jtag_req_addr_i   (dmi_req_addr_i),
    .jtag_req_op_i     (dmi_req_op_i),
    .jtag_req_data_i   (dmi_req_data_i),
    .jtag_resp_valid_o (dmi_resp_valid_o),
    .jtag_resp_ready_i (dmi_resp_ready_i),
    .jtag_resp_data_o  (dmi_resp_data_o),
    .jtag_resp_code_o  (dmi_resp_code_o),
    .jtag_cdc_clear_i  (dmi_cdc_clear_i),
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .core_rst_no       (core_rst_n),
    .core_req_valid_o  (core_req_valid),
    .core_req_ready_i  (core_req_ready),
    .core_req_addr_o   (core_req_addr),
    .core_req_op_o     (core_req_op),
    .core_req_data_o   (core_req_data),
    .core_resp_valid_i (core_resp_valid),
    .core_resp_ready_o (core_resp_ready),
    .core_resp_data_i  (core_resp_data),
    .core_resp_code_i  (core_resp_code)
  );

  // Register target, cleared with the core half of the crossing
  dmi_regfile #(
    .NumData(NumData)
  ) u_dmi_regfile (
    .clk_i        (clk_i),
    .rst_ni       (core_rst_n),
    .req_valid_i  (core_req_valid),
    .req_ready_o  (core_req_ready),
    .req_addr_i   (core_req_addr),
    .req_op_i     (core_req_op),
    .req_data_i   (core_req_data),
    .resp_valid_o (core_resp_valid),
    .resp_ready_i (core_resp_ready),
    .resp_data_o  (core_resp_data),
    .resp_code_o  (core_resp_code)
  );

endmodule

//--- logic/dmi_regfile.sv
`timescale 1ns/1ps

module dmi_regfile #(
  // Data registers at DataBaseAddr upward
  parameter int unsigned NumData = 4
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // Request in
  input  logic                          req_valid_i,
  output logic                          req_ready_o,
  input  logic [dmi_pkg::AddrWidth-1:0] req_addr_i,
  input  dmi_pkg::dmi_op_e              req_op_i,
  input  logic [dmi_pkg::DataWidth-1:0] req_data_i,
  // Response out
  output logic                          resp_valid_o,
  input  logic                          resp_ready_i,
  output logic [dmi_pkg::DataWidth-1:0] resp_data_o,
  output dmi_pkg::dmi_resp_e            resp_code_o
);

  // Index width, kept at least one bit
  localparam int unsigned IdxWidth = (NumData > 1) ? $clog2(NumData) : 1;

  logic [NumData-1:0][dmi_pkg::DataWidth-1:0] data_q;
  logic [dmi_pkg::AddrWidth-1:0]              offset;
  logic [IdxWidth-1:0]                        data_idx;
  logic                                       data_hit;
  logic                                       id_hit;
  logic                                       accept;
  logic                                       wr_en;
  logic                                       resp_valid_q;
  logic [dmi_pkg::DataWidth-1:0]              resp_data_d;
  logic [dmi_pkg::DataWidth-1:0]              resp_data_q;
  dmi_pkg::dmi_resp_e                         resp_code_d;
  dmi_pkg::dmi_resp_e                         resp_code_q;

  // Register count must fit the map
  if ((NumData < 1) || (NumData > dm_map_pkg::MaxDataRegs)) begin : gen_num_data_check
    $error("NumData out of range");
  end

  // Addresses below the base wrap to large offsets and miss
  assign offset   = req_addr_i - dm_map_pkg::DataBaseAddr;
  assign data_hit = (offset < NumData);
  assign data_idx = offset[IdxWidth-1:0];
  assign id_hit   = (req_addr_i == dm_map_pkg::IdAddr);

  // One request at a time
  // busy from acceptance until the response is taken
  assign req_ready_o = ~resp_valid_q;
  assign accept      = req_valid_i & req_ready_o;

  // Decode into response and write enable
  always_comb begin
    resp_data_d = '0;
    resp_code_d = dmi_pkg::DMI_SUCCESS;
    wr_en       = 1'b0;
    case (req_op_i)
      dmi_pkg::DMI_NOP: begin
        resp_data_d = '0;
      end
      dmi_pkg::DMI_READ: begin
        if (data_hit) begin
          resp_data_d = data_q[data_idx];
        end else if (id_hit) begin
          resp_data_d = dm_map_pkg::IdValue;
        end else begin
          resp_code_d = dmi_pkg::DMI_FAILED;
        end
      end
      dmi_pkg::DMI_WRITE: begin
        // ID is read-only, writes there fail like unmapped ones
        if (data_hit) begin
          wr_en = 1'b1;
        end else begin
          resp_code_d = dmi_pkg::DMI_FAILED;
        end
      end
      default: begin
        resp_code_d = dmi_pkg::DMI_FAILED;
      end
    endcase
  end

  // Response valid one cycle after acceptance
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resp_valid_q <= 1'b0;
      data_q       <= {NumData{dm_map_pkg::DataResetValue}};
    end else begin
      if (accept) begin
        resp_valid_q <= 1'b1;
      end else if (resp_ready_i) begin
        resp_valid_q <= 1'b0;
      end
      if (accept && wr_en) begin
        data_q[data_idx] <= req_data_i;
      end
    end
  end

  // Response payload held while pending
  always_ff @(posedge clk_i) begin
    if (accept) begin
      resp_data_q <= resp_data_d;
      resp_code_q <= resp_code_d;
    end
  end

  assign resp_valid_o = resp_valid_q;
  assign resp_data_o  = resp_data_q;
  assign resp_code_o  = resp_code_q;

endmodule

//--- logic/dmi_cdc.sv
`timescale 1ns/1ps

module dmi_cdc (
  // Test controls
  input  logic                                testmode_i,
  input  logic                                test_rst_ni,
  // JTAG side
  input  logic                                tck_i,
  input  logic                                trst_ni,
  input  logic                                jtag_req_valid_i,
  output logic                                jtag_req_ready_o,
  input  logic [dmi_pkg::AddrWidth-1:0]       jtag_req_addr_i,
  input  dmi_pkg::dmi_op_e                    jtag_req_op_i,
  input  logic [dmi_pkg::DataWidth-1:0]       jtag_req_data_i,
  output logic                                jtag_resp_valid_o,
  input  logic                                jtag_resp_ready_i,
  output logic [dmi_pkg::DataWidth-1:0]       jtag_resp_data_o,
  output dmi_pkg::dmi_resp_e                  jtag_resp_code_o,
  // Holds the core side in reset while high
  input  logic                                jtag_cdc_clear_i,
  // Core side
  input  logic                                clk_i,
  input  logic                                rst_ni,
  output logic                                core_rst_no,
  output logic                                core_req_valid_o,
  input  logic                                core_req_ready_i,
  output logic [dmi_pkg::AddrWidth-1:0]       core_req_addr_o,
  output dmi_pkg::dmi_op_e                    core_req_op_o,
  output logic [dmi_pkg::DataWidth-1:0]       core_req_data_o,
  input  logic                                core_resp_valid_i,
  output logic                                core_resp_ready_o,
  input  logic [dmi_pkg::DataWidth-1:0]       core_resp_data_i,
  input  dmi_pkg::dmi_resp_e                  core_resp_code_i
);

  logic               jtag_rst_n_q;
  logic               core_rst_n_premux;
  logic               core_rst_n;
  dmi_pkg::dmi_req_t  jtag_req;
  dmi_pkg::dmi_req_t  core_req;
  dmi_pkg::dmi_resp_t core_resp;
  dmi_pkg::dmi_resp_t jtag_resp;

  // Clear registered in the JTAG domain
  always_ff @(posedge tck_i or negedge trst_ni) begin
    if (!trst_ni) begin
      jtag_rst_n_q <= 1'b0;
    end else begin
      jtag_rst_n_q <= ~jtag_cdc_clear_i;
    end
  end

  // Asserts at once, releases synchronous to clk_i
  sync_2ff #(
    .ResetValue(1'b0)
  ) u_core_rst_sync (
    .clk_i  (clk_i),
    .rst_ni (rst_ni & jtag_rst_n_q),
    .d_i    (1'b1),
    .q_o    (core_rst_n_premux)
  );

  // External test reset takes over in test mode
  assign core_rst_n  = testmode_i ? test_rst_ni : core_rst_n_premux;
  assign core_rst_no = core_rst_n;

  // Request fields packed for the crossing
  assign jtag_req.addr = jtag_req_addr_i;
  assign jtag_req.op   = jtag_req_op_i;
  assign jtag_req.data = jtag_req_data_i;

  // Request path, JTAG writes and core reads
  cdc_handshake #(
    .payload_t(dmi_pkg::dmi_req_t)
  ) u_cdc_req (
    .clk_wr_i  (tck_i),
    .rst_wr_ni (trst_ni),
    .wvalid_i  (jtag_req_valid_i),
    .wready_o  (jtag_req_ready_o),
    .wdata_i   (jtag_req),
    .clk_rd_i  (clk_i),
    .rst_rd_ni (core_rst_n),
    .rvalid_o  (core_req_valid_o),
    .rready_i  (core_req_ready_i),
    .rdata_o   (core_req)
  );

  assign core_req_addr_o = core_req.addr;
  assign core_req_op_o   = core_req.op;
  assign core_req_data_o = core_req.data;

  // Response fields packed for the way back
  assign core_resp.data = core_resp_data_i;
  assign core_resp.resp = core_resp_code_i;

  // Response path, core writes and JTAG reads
  cdc_handshake #(
    .payload_t(dmi_pkg::dmi_resp_t)
  ) u_cdc_resp (
    .clk_wr_i  (clk_i),
    .rst_wr_ni (core_rst_n),
    .wvalid_i  (core_resp_valid_i),
    .wready_o  (core_resp_ready_o),
    .wdata_i   (core_resp),
    .clk_rd_i  (tck_i),
    .rst_rd_ni (trst_ni),
    .rvalid_o  (jtag_resp_valid_o),
    .rready_i  (jtag_resp_ready_i),
    .rdata_o   (jtag_resp)
  );

  assign jtag_resp_data_o = jtag_resp.data;
  assign jtag_resp_code_o = jtag_resp.resp;

endmodule

//--- logic/cdc_handshake.sv
`timescale 1ns/1ps

module cdc_handshake #(
  // Struct carried across the crossing
  parameter type payload_t = logic
) (
  // Write side
  input  logic     clk_wr_i,
  input  logic     rst_wr_ni,
  input  logic     wvalid_i,
  output logic     wready_o,
  input  payload_t wdata_i,
  // Read side
  input  logic     clk_rd_i,
  input  logic     rst_rd_ni,
  output logic     rvalid_o,
  input  logic     rready_i,
  output payload_t rdata_o
);

  // Write domain
  logic     req_q;
  logic     ack_wr;
  logic     wr_fire;
  payload_t payload_q;

  // Read domain
  logic     ack_q;
  logic     req_rd;
  logic     rd_fire;

  // Ready only out of reset with req and ack both back at zero
  assign wready_o = rst_wr_ni & ~req_q & ~ack_wr;
  assign wr_fire  = wvalid_i & wready_o;

  // Req phase
  // rises on a write, drops once ack comes back
  always_ff @(posedge clk_wr_i or negedge rst_wr_ni) begin
    if (!rst_wr_ni) begin
      req_q <= 1'b0;
    end else if (wr_fire) begin
      req_q <= 1'b1;
    end else if (req_q && ack_wr) begin
      req_q <= 1'b0;
    end
  end

  // Payload loaded together with the req rise
  always_ff @(posedge clk_wr_i) begin
    if (wr_fire) begin
      payload_q <= wdata_i;
    end
  end

  // Req level into the read domain
  sync_2ff #(
    .ResetValue(1'b0)
  ) u_req_sync (
    .clk_i  (clk_rd_i),
    .rst_ni (rst_rd_ni),
    .d_i    (req_q),
    .q_o    (req_rd)
  );

  // Item offered until the reader takes it
  assign rvalid_o = req_rd & ~ack_q;
  assign rd_fire  = rvalid_o & rready_i;

  // Ack phase
  // rises on take, drops after req is seen low
  always_ff @(posedge clk_rd_i or negedge rst_rd_ni) begin
    if (!rst_rd_ni) begin
      ack_q <= 1'b0;
    end else if (rd_fire) begin
      ack_q <= 1'b1;
    end else if (ack_q && !req_rd) begin
      ack_q <= 1'b0;
    end
  end

  // Ack level back into the write domain
  sync_2ff #(
    .ResetValue(1'b0)
  ) u_ack_sync (
    .clk_i  (clk_wr_i),
    .rst_ni (rst_wr_ni),
    .d_i    (ack_q),
    .q_o    (ack_wr)
  );

  // Payload stays frozen while req is high so the reader can take it directly
  assign rdata_o = payload_q;

endmodule

//--- logic/sync_2ff.sv
`timescale 1ns/1ps

module sync_2ff #(
  // Level both flops take during reset
  parameter logic ResetValue = 1'b0
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic d_i,
  output logic q_o
);

  // First stage may go metastable
  logic meta_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      meta_q <= ResetValue;
      q_o    <= ResetValue;
    end else begin
      meta_q <= d_i;
      // Second stage settles the level
      q_o    <= meta_q;
    end
  end

endmodule

//--- logic/dm_map_pkg.sv
package dm_map_pkg;

  // First data register, data k sits at base plus k
  localparam logic [dmi_pkg::AddrWidth-1:0] DataBaseAddr = 7'h04;

  // Read-only identification register
  localparam logic [dmi_pkg::AddrWidth-1:0] IdAddr = 7'h12;

  // Constant returned on ID reads
  localparam logic [dmi_pkg::DataWidth-1:0] IdValue = 32'h0d1e_5013;

  // Value of every data register after reset
  localparam logic [dmi_pkg::DataWidth-1:0] DataResetValue = 32'h0000_0000;

  // Upper bound on data registers
  // keeps the data window clear of the ID address
  localparam int unsigned MaxDataRegs = 12;

endpackage

//--- logic/dmi_pkg.sv
package dmi_pkg;

  // DMI field widths
  localparam int unsigned AddrWidth = 7;
  localparam int unsigned DataWidth = 32;

  // Request operation
  typedef enum logic [1:0] {
    DMI_NOP   = 2'h0,
    DMI_READ  = 2'h1,
    DMI_WRITE = 2'h2
  } dmi_op_e;

  // Response code, value 1 stays reserved
  typedef enum logic [1:0] {
    DMI_SUCCESS = 2'h0,
    DMI_FAILED  = 2'h2
  } dmi_resp_e;

  // Request as it crosses into the core domain
  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    dmi_op_e              op;
    logic [DataWidth-1:0] data;
  } dmi_req_t;

  // Response as it crosses back to the JTAG domain
  typedef struct packed {
    logic [DataWidth-1:0] data;
    dmi_resp_e            resp;
  } dmi_resp_t;

endpackage
